// ==== source/bus_defines.svh ====
// Bus and board constants for the DE0 style bus system
// Widths, address map, handshake timeout and reset stretch length
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Byte address, bit 0 ignored
`define BUS_ADDR_W     16
`define BUS_DATA_W     16

// RAM covers 0x0000..0x03FE
`define RAM_WORDS      512

// Panel registers at base+0, base+2, base+4
`define PANEL_BASE     16'hFF00

// Cycles to wait for slave sync
`define BUS_TIMEOUT    32

// Cycles held in reset after arst_n release
`define RESET_STRETCH  16

`endif

// ==== source/bus_pkg.sv ====
// Bus types shared by the master and the slaves
// Address and data words, master cycle state encoding
package bus_pkg;

`include "bus_defines.svh"

   typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;    // Byte address
   typedef logic [`BUS_DATA_W-1:0] bus_word_t;    // Data word

   // Bus cycle sequence of the master
   typedef enum logic [2:0]
   {
      ms_idle,                                    // Waiting for a command
      ms_address,                                 // Address and data set up
      ms_wait_sync,                               // msyn high, waiting for ssyn
      ms_release,                                 // msyn low, waiting for ssyn low
      ms_respond                                  // Response pulse
   } master_state_t;

endpackage

// ==== source/board_pkg.sv ====
// Front panel types for the DE0 board outputs and inputs
// Seven segment digits, LEDs, switches and the slave handshake states
package board_pkg;

   typedef logic [7:0] seg7_t;                    // Active low, bit 7 is the point
   typedef logic [9:0] led_t;                     // Green LEDs
   typedef logic [9:0] sw_t;                      // Toggle switches

   // Slave side of the msyn/ssyn handshake
   typedef enum logic
   {
      ss_idle,                                    // Waiting for msyn
      ss_ack                                      // ssyn high until msyn drops
   } slave_state_t;

endpackage

// ==== source/reset_gen.sv ====
// Power-on reset generator
// Synchronizes the board reset and holds the system in reset for a fixed count
`timescale 1ns/1ps

`include "bus_defines.svh"

module reset_gen
(
   input  logic clk,
   input  logic arst_n,
   output logic sys_rst_n
);

   localparam int cnt_w = $clog2(`RESET_STRETCH + 1);

   logic [1:0]       sync_q;                      // Release synchronizer
   logic [cnt_w-1:0] cnt_q;                       // Stretch counter
   logic             rst_q;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sync_q <= 2'b00;
         cnt_q  <= '0;
         rst_q  <= 1'b0;
      end
      else
      begin
         sync_q <= {sync_q[0], 1'b1};
         if (sync_q[1] && cnt_q != cnt_w'(`RESET_STRETCH))
            cnt_q <= cnt_q + 1'b1;                // Saturates at the stretch length
         if (sync_q[1] && cnt_q == cnt_w'(`RESET_STRETCH - 1))
            rst_q <= 1'b1;                        // Same edge the count completes
      end
   end

   assign sys_rst_n = rst_q;                      // Asserted async with arst_n

endmodule

// ==== source/bus_master.sv ====
// Bus master with a command/response port
// Runs one msyn/ssyn read or write cycle per command, with a bus timeout
`timescale 1ns/1ps

`include "bus_defines.svh"

module bus_master
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               cmd_valid,
   input  logic               cmd_write,
   input  bus_pkg::bus_addr_t cmd_addr,
   input  bus_pkg::bus_word_t cmd_wdata,
   output logic               cmd_ready,
   output logic               rsp_valid,
   output bus_pkg::bus_word_t rsp_rdata,
   output logic               rsp_error,
   output bus_pkg::bus_addr_t bus_addr,
   output bus_pkg::bus_word_t bus_wdata,
   output logic               bus_write,
   output logic               bus_msyn,
   input  logic               bus_ssyn,
   input  bus_pkg::bus_word_t bus_rdata
);

   import bus_pkg::*;

   localparam int tmo_w = $clog2(`BUS_TIMEOUT + 1);

   master_state_t    state, state_next;
   logic [tmo_w-1:0] tmo_cnt;                     // Cycles spent in wait_sync
   logic             accept;                      // Command handshake
   logic             timeout;
   logic             cycle_end;                   // Leaving wait_sync

   assign accept    = cmd_valid & cmd_ready;
   assign timeout   = (tmo_cnt == tmo_w'(`BUS_TIMEOUT));
   assign cycle_end = (state == ms_wait_sync) && (state_next == ms_release);

   always_comb
   begin
      state_next = state;
      case (state)
         ms_idle:
         begin
            if (accept)
               state_next = ms_address;
         end
         ms_address:
            state_next = ms_wait_sync;            // msyn one cycle after address
         ms_wait_sync:
         begin
            if (bus_ssyn || timeout)
               state_next = ms_release;
         end
         ms_release:
         begin
            if (!bus_ssyn)
               state_next = ms_respond;           // Slave has let go of ssyn
         end
         ms_respond:
            state_next = ms_idle;
         default:
            state_next = ms_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= ms_idle;
         tmo_cnt   <= '0;
         cmd_ready <= 1'b0;                       // Held low through system reset
         rsp_error <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         cmd_ready <= (state_next == ms_idle);
         if (state == ms_wait_sync)
            tmo_cnt <= tmo_cnt + 1'b1;
         else
            tmo_cnt <= '0;
         if (cycle_end)
            rsp_error <= !bus_ssyn;               // No slave answered
      end
   end

   // Command latch and response data
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         bus_addr  <= cmd_addr;
         bus_wdata <= cmd_wdata;
         bus_write <= cmd_write;
      end
      if (cycle_end)
         rsp_rdata <= (bus_ssyn && !bus_write) ? bus_rdata : '0;
   end

   assign bus_msyn  = (state == ms_wait_sync);
   assign rsp_valid = (state == ms_respond);

   // A new cycle must not start over a slave still holding ssyn
   a_msyn_after_ssyn: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(bus_msyn) |-> !bus_ssyn);

   // One response pulse per command
   a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |=> !rsp_valid);

endmodule

// ==== source/bus_ram.sv ====
// Word RAM slave on the msyn/ssyn bus
// Decodes the low address range, registered read, one cycle ssyn response
`timescale 1ns/1ps

`include "bus_defines.svh"

module bus_ram
(
   input  logic               clk,
   input  logic               arst_n,
   input  bus_pkg::bus_addr_t bus_addr,
   input  bus_pkg::bus_word_t bus_wdata,
   input  logic               bus_write,
   input  logic               bus_msyn,
   output logic               ssyn,
   output bus_pkg::bus_word_t rdata
);

   import bus_pkg::*;
   import board_pkg::*;

   localparam int idx_w = $clog2(`RAM_WORDS);

   bus_word_t        mem [`RAM_WORDS];
   bus_word_t        rd_q;
   logic [idx_w-1:0] idx;
   logic             sel;
   logic             start;                       // First msyn cycle of an access
   slave_state_t     state;

   assign idx   = bus_addr[idx_w:1];              // Word index, bit 0 dropped
   assign sel   = (bus_addr[`BUS_ADDR_W-1:idx_w+1] == '0);
   assign start = (state == ss_idle) && bus_msyn && sel;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= ss_idle;
      else if (start)
         state <= ss_ack;
      else if (state == ss_ack && !bus_msyn)
         state <= ss_idle;                        // Master released msyn
   end

   always_ff @(posedge clk)
   begin
      if (start && bus_write)
         mem[idx] <= bus_wdata;
      if (start)
         rd_q <= mem[idx];                        // Old word on a write
   end

   assign ssyn  = (state == ss_ack);
   assign rdata = ssyn ? rd_q : '0;               // Quiet when not answering

   // ssyn rises only while the master still holds msyn
   a_ram_ssyn: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(ssyn) |-> bus_msyn);

endmodule

// ==== source/panel_regs.sv ====
// Front panel slave with hex digit and LED registers and switch readback
// Drives four seven segment digits from the hex register nibbles
`timescale 1ns/1ps

`include "bus_defines.svh"

module panel_regs
(
   input  logic               clk,
   input  logic               arst_n,
   input  bus_pkg::bus_addr_t bus_addr,
   input  bus_pkg::bus_word_t bus_wdata,
   input  logic               bus_write,
   input  logic               bus_msyn,
   input  board_pkg::sw_t     sw,
   output logic               ssyn,
   output bus_pkg::bus_word_t rdata,
   output board_pkg::seg7_t   hex0,
   output board_pkg::seg7_t   hex1,
   output board_pkg::seg7_t   hex2,
   output board_pkg::seg7_t   hex3,
   output board_pkg::led_t    led
);

   import bus_pkg::*;
   import board_pkg::*;

   localparam bus_addr_t base = `PANEL_BASE;

   bus_word_t    hex_q;
   led_t         led_q;
   sw_t          sw_meta, sw_sync;                // Switch synchronizer
   bus_word_t    rd_q;
   logic [1:0]   reg_idx;
   logic         sel, start;
   slave_state_t state;

   // Hex nibble to active low segments, point off
   function automatic seg7_t seg7_encode(input logic [3:0] nib);
      logic [6:0] seg;                            // g..a
      case (nib)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'hA: seg = 7'h08;
         4'hB: seg = 7'h03;                       // Lower case b
         4'hC: seg = 7'h46;
         4'hD: seg = 7'h21;                       // Lower case d
         4'hE: seg = 7'h06;
         default: seg = 7'h0E;
      endcase
      return {1'b1, seg};
   endfunction

   assign reg_idx = bus_addr[2:1];
   assign sel     = (bus_addr[`BUS_ADDR_W-1:3] == base[`BUS_ADDR_W-1:3]) && (reg_idx != 2'd3);
   assign start   = (state == ss_idle) && bus_msyn && sel;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= ss_idle;
         hex_q   <= '0;
         led_q   <= '0;
         sw_meta <= '0;
         sw_sync <= '0;
      end
      else
      begin
         sw_meta <= sw;
         sw_sync <= sw_meta;
         if (start)
            state <= ss_ack;
         else if (state == ss_ack && !bus_msyn)
            state <= ss_idle;
         if (start && bus_write && reg_idx == 2'd0)
            hex_q <= bus_wdata;
         if (start && bus_write && reg_idx == 2'd1)
            led_q <= bus_wdata[9:0];              // Switch writes fall through
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         case (reg_idx)
            2'd0:    rd_q <= hex_q;
            2'd1:    rd_q <= {6'b0, led_q};
            default: rd_q <= {6'b0, sw_sync};
         endcase
      end
   end

   assign ssyn  = (state == ss_ack);
   assign rdata = ssyn ? rd_q : '0;
   assign hex0  = seg7_encode(hex_q[3:0]);        // Rightmost digit
   assign hex1  = seg7_encode(hex_q[7:4]);
   assign hex2  = seg7_encode(hex_q[11:8]);
   assign hex3  = seg7_encode(hex_q[15:12]);
   assign led   = led_q;

   a_panel_ssyn: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(ssyn) |-> bus_msyn);

endmodule

// ==== source/de0_top.sv ====
// DE0 style system top
// Reset generator, bus master, word RAM and front panel on one shared bus
`timescale 1ns/1ps

module de0_top
(
   input  logic               clk,
   input  logic               arst_n,             // Board reset button
   input  board_pkg::sw_t     sw,
   input  logic               cmd_valid,
   input  logic               cmd_write,
   input  bus_pkg::bus_addr_t cmd_addr,
   input  bus_pkg::bus_word_t cmd_wdata,
   output logic               cmd_ready,
   output logic               rsp_valid,
   output bus_pkg::bus_word_t rsp_rdata,
   output logic               rsp_error,
   output board_pkg::seg7_t   hex0,
   output board_pkg::seg7_t   hex1,
   output board_pkg::seg7_t   hex2,
   output board_pkg::seg7_t   hex3,
   output board_pkg::led_t    led
);

   import bus_pkg::*;

   logic      sys_rst_n;
   bus_addr_t bus_addr;
   bus_word_t bus_wdata, bus_rdata;
   logic      bus_write, bus_msyn, bus_ssyn;
   logic      ram_ssyn, panel_ssyn;
   bus_word_t ram_rdata, panel_rdata;

   reset_gen reset_gen_i
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .sys_rst_n (sys_rst_n)
   );

   bus_master bus_master_i
   (
      .clk       (clk),
      .arst_n    (sys_rst_n),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .cmd_ready (cmd_ready),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata),
      .rsp_error (rsp_error),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .bus_msyn  (bus_msyn),
      .bus_ssyn  (bus_ssyn),
      .bus_rdata (bus_rdata)
   );

   bus_ram bus_ram_i
   (
      .clk       (clk),
      .arst_n    (sys_rst_n),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .bus_msyn  (bus_msyn),
      .ssyn      (ram_ssyn),
      .rdata     (ram_rdata)
   );

   panel_regs panel_regs_i
   (
      .clk       (clk),
      .arst_n    (sys_rst_n),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .bus_msyn  (bus_msyn),
      .sw        (sw),
      .ssyn      (panel_ssyn),
      .rdata     (panel_rdata),
      .hex0      (hex0),
      .hex1      (hex1),
      .hex2      (hex2),
      .hex3      (hex3),
      .led       (led)
   );

   // Wired-OR bus return, idle slaves drive zero
   assign bus_ssyn  = ram_ssyn | panel_ssyn;
   assign bus_rdata = ram_rdata | panel_rdata;

endmodule

// ==== testbench/tb_clock.sv ====
// Testbench clock source
// Free running 8 ns clock
`timescale 1ns/1ps

module tb_clock
(
   output logic clk
);

   localparam realtime half_period = 4.0;         // 125 MHz

   initial
   begin
      clk = 1'b0;
      forever
         #(half_period) clk = ~clk;
   end

endmodule

// ==== testbench/tb_de0.sv ====
// Testbench for the DE0 style bus system
// Random RAM and panel traffic checked against a reference model
`timescale 1ns/1ps

`include "bus_defines.svh"

module tb_de0;

   import bus_pkg::*;
   import board_pkg::*;

   localparam bus_addr_t panel = `PANEL_BASE;
   localparam int n_wr = 40;                      // RAM writes in the random phase

   logic      clk;
   logic      arst_n;
   sw_t       sw;
   logic      cmd_valid, cmd_write;
   bus_addr_t cmd_addr;
   bus_word_t cmd_wdata;
   logic      cmd_ready, rsp_valid, rsp_error;
   bus_word_t rsp_rdata;
   seg7_t     hex0, hex1, hex2, hex3;
   led_t      led;

   integer    seed = 32'hb364582e;
   integer    errors = 0;
   integer    checks = 0;
   logic      hung = 1'b0;                        // A wait gave up

   // Reference model
   bus_word_t  ram_model [`RAM_WORDS];
   bit         known [`RAM_WORDS];                // Word written at least once
   logic [8:0] wr_idx [n_wr];
   bus_word_t  hex_model;
   led_t       led_model;

   // Lit segments per digit, gfedcba, standard shapes
   logic [6:0] seg_on [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                               7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

   tb_clock clock_i (.clk(clk));

   de0_top dut_i
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .sw        (sw),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .cmd_ready (cmd_ready),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata),
      .rsp_error (rsp_error),
      .hex0      (hex0),
      .hex1      (hex1),
      .hex2      (hex2),
      .hex3      (hex3),
      .led       (led)
   );

   // {hex3, hex2, hex1, hex0} for a register value, active low, point off
   function automatic logic [31:0] expected_digits(input bus_word_t value);
      return {1'b1, ~seg_on[value[15:12]], 1'b1, ~seg_on[value[11:8]],
              1'b1, ~seg_on[value[7:4]], 1'b1, ~seg_on[value[3:0]]};
   endfunction

   // Address map: RAM at the bottom, three panel registers at the base
   function automatic logic is_decoded(input bus_addr_t addr);
      return (int'(addr) < 2 * `RAM_WORDS) ||
             (addr[15:3] == panel[15:3] && addr[2:1] != 2'd3);
   endfunction

   // Reports a stuck wait and parks the stimulus for good
   task automatic abort_run(input string what);
      $display("timeout: %s", what);
      errors++;
      hung = 1'b1;
      forever
         @(posedge clk);
   endtask

   // Ends the run once a wait has given up
   initial
   begin
      wait (hung);
      $display("checks %0d, errors %0d", checks, errors);
      $display("TB FAILED");
      $finish;
   end

   // One transfer, called and left on a falling edge
   task automatic run_cmd(input logic write, input bus_addr_t addr, input bus_word_t wdata,
                          output bus_word_t rdata);
      int wait_cnt;
      int latency;
      int exp_lat;
      wait_cnt = 0;
      exp_lat  = is_decoded(addr) ? 5 : `BUS_TIMEOUT + 3;
      while (!cmd_ready && wait_cnt < 64)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!cmd_ready)
         abort_run("cmd_ready stayed low before a command");
      cmd_valid = 1'b1;
      cmd_write = write;
      cmd_addr  = addr;
      cmd_wdata = wdata;
      @(negedge clk);                             // Accepted on the rising edge
      cmd_valid = 1'b0;
      latency   = 0;                              // Rising edges since acceptance
      while (!rsp_valid && latency < `BUS_TIMEOUT + 16)
      begin
         checks++;
         if (cmd_ready)
         begin
            errors++;
            $display("error cmd_ready: got 0x1, expected 0x0 (addr 0x%h)", addr);
         end
         @(negedge clk);
         latency++;
      end
      if (!rsp_valid)
         abort_run("no rsp_valid after a command");
      checks += 3;
      if (cmd_ready)
      begin
         errors++;
         $display("error cmd_ready: got 0x1 during the response, expected 0x0");
      end
      if (latency != exp_lat)
      begin
         errors++;
         $display("response to addr 0x%h took %0d cycles instead of %0d",
                  addr, latency, exp_lat);
      end
      if (rsp_error !== !is_decoded(addr))
      begin
         errors++;
         $display("error rsp_error: got 0x%h, expected 0x%h (addr 0x%h)",
                  rsp_error, !is_decoded(addr), addr);
      end
      if (!is_decoded(addr) && rsp_rdata !== 16'h0000)
      begin
         errors++;
         $display("error rsp_rdata: got 0x%h, expected 0x0000 (addr 0x%h)", rsp_rdata, addr);
      end
      rdata = rsp_rdata;
   endtask

   initial
   begin
      logic [31:0] rnd;
      logic [31:0] val;
      logic [8:0]  idx;
      bus_word_t   rd;
      bus_addr_t   addr;
      int          wait_cnt;
      arst_n    = 1'b0;
      sw        = '0;
      cmd_valid = 1'b0;
      cmd_write = 1'b0;
      cmd_addr  = '0;
      cmd_wdata = '0;
      hex_model = '0;
      led_model = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n   = 1'b1;
      wait_cnt = 0;
      while (!cmd_ready && wait_cnt < 64)         // Stretch plus synchronizer
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!cmd_ready)
         abort_run("cmd_ready did not rise after reset");
      checks += 2;
      if ({hex3, hex2, hex1, hex0} !== expected_digits(16'h0000))
      begin
         errors++;
         $display("error hex3..hex0: got 0x%h, expected 0x%h",
                  {hex3, hex2, hex1, hex0}, expected_digits(16'h0000));
      end
      if (led !== 10'h000)
      begin
         errors++;
         $display("error led: got 0x%h, expected 0x000", led);
      end

      // Random RAM writes, odd byte addresses included
      for (int i = 0; i < n_wr; i++)
      begin
         rnd = $random(seed);
         val = $random(seed);
         idx = rnd[8:0];
         run_cmd(1'b1, {6'b0, idx, rnd[9]}, val[15:0], rd);
         ram_model[idx] = val[15:0];
         known[idx]     = 1'b1;
         wr_idx[i]      = idx;
      end
      // Reads, half of them from words known to be written
      for (int i = 0; i < 60; i++)
      begin
         rnd = $random(seed);
         idx = rnd[16] ? wr_idx[int'(rnd[15:10]) % n_wr] : rnd[8:0];
         run_cmd(1'b0, {6'b0, idx, 1'b0}, 16'h0000, rd);
         checks++;
         if (known[idx] && rd !== ram_model[idx])
         begin
            errors++;
            $display("error rsp_rdata: got 0x%h, expected 0x%h (word %0d)",
                     rd, ram_model[idx], idx);
         end
      end

      // Hex and LED registers
      for (int i = 0; i < 4; i++)
      begin
         val = $random(seed);
         run_cmd(1'b1, panel, val[15:0], rd);
         hex_model = val[15:0];
         run_cmd(1'b1, panel + 16'd2, val[31:16], rd);
         led_model = val[25:16];
         checks += 2;
         if ({hex3, hex2, hex1, hex0} !== expected_digits(hex_model))
         begin
            errors++;
            $display("error hex3..hex0: got 0x%h, expected 0x%h",
                     {hex3, hex2, hex1, hex0}, expected_digits(hex_model));
         end
         if (led !== led_model)
         begin
            errors++;
            $display("error led: got 0x%h, expected 0x%h", led, led_model);
         end
         run_cmd(1'b0, panel, 16'h0000, rd);
         checks++;
         if (rd !== hex_model)
         begin
            errors++;
            $display("error rsp_rdata: got 0x%h, expected 0x%h (hex)", rd, hex_model);
         end
         run_cmd(1'b0, panel + 16'd2, 16'h0000, rd);
         checks++;
         if (rd !== {6'b0, led_model})
         begin
            errors++;
            $display("error rsp_rdata: got 0x%h, expected 0x%h (led)", rd, {6'b0, led_model});
         end
      end

      // Switch readback and ignored switch writes
      for (int i = 0; i < 4; i++)
      begin
         rnd = $random(seed);
         sw  = rnd[9:0];
         repeat (3) @(negedge clk);               // Through the switch synchronizer
         run_cmd(1'b0, panel + 16'd4, 16'h0000, rd);
         checks++;
         if (rd !== {6'b0, sw})
         begin
            errors++;
            $display("error rsp_rdata: got 0x%h, expected 0x%h (sw)", rd, {6'b0, sw});
         end
         run_cmd(1'b1, panel + 16'd4, rnd[31:16], rd);
         checks++;
         if (led !== led_model || {hex3, hex2, hex1, hex0} !== expected_digits(hex_model))
         begin
            errors++;
            $display("error led/hex after a switch write: got 0x%h/0x%h, expected 0x%h/0x%h",
                     led, {hex3, hex2, hex1, hex0}, led_model, expected_digits(hex_model));
         end
      end

      // Undecoded addresses, each written and read
      for (int i = 0; i < 8; i++)
      begin
         rnd = $random(seed);
         case (i)
            0:       addr = 16'h8000;
            1:       addr = 16'h0400;             // Just above the RAM
            2:       addr = panel + 16'd6;        // Hole after the switches
            3:       addr = panel + 16'd8;
            default: addr = {1'b0, rnd[14:12] | 3'b001, rnd[11:0]};
         endcase
         run_cmd(1'b1, addr, rnd[31:16], rd);
         run_cmd(1'b0, addr, 16'h0000, rd);
      end
      for (int i = 0; i < n_wr; i++)
      begin
         run_cmd(1'b0, {6'b0, wr_idx[i], 1'b0}, 16'h0000, rd);
         checks++;
         if (rd !== ram_model[wr_idx[i]])
         begin
            errors++;
            $display("error rsp_rdata: got 0x%h, expected 0x%h (word %0d)",
                     rd, ram_model[wr_idx[i]], wr_idx[i]);
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+source
source/bus_pkg.sv
source/board_pkg.sv
source/reset_gen.sv
source/bus_master.sv
source/bus_ram.sv
source/panel_regs.sv
source/de0_top.sv
testbench/tb_clock.sv
testbench/tb_de0.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_de0
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the simulation prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
